// ==== hw/uart_pkg.sv ====
// ----------------------------------------------------------------------
// UART peripheral package
// Frame and FIFO constants, register map, AXI4-Lite bus structs and
// the receiver and transmitter state encodings
// ----------------------------------------------------------------------
package uart_pkg;

    localparam int DATA_BITS  = 8;                      // Data bits per frame
    localparam int OVERSAMPLE = 16;                     // Ticks per bit period
    localparam int STOP_TICKS = 16;                     // One stop bit
    localparam int FIFO_AW    = 2;                      // 4 entries per FIFO
    localparam int DIV_W      = 16;                     // Divisor width
    localparam logic [DIV_W-1:0] DIV_RESET = 16'd4;     // Divisor out of reset

    localparam int TICK_W = $clog2(OVERSAMPLE);         // Tick counter width
    localparam int BIT_W  = $clog2(DATA_BITS);          // Bit index width
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(OVERSAMPLE - 1);
    localparam logic [TICK_W-1:0] TICK_HALF = TICK_W'(OVERSAMPLE / 2 - 1);
    localparam logic [TICK_W-1:0] STOP_LAST = TICK_W'(STOP_TICKS - 1);
    localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(DATA_BITS - 1);

    localparam logic [3:0] ADDR_DATA    = 4'h0;         // TX push / RX pop
    localparam logic [3:0] ADDR_STATUS  = 4'h4;         // FIFO flags, overrun
    localparam logic [3:0] ADDR_DIVISOR = 4'h8;         // Baud divisor
    localparam logic [3:0] ADDR_CTRL    = 4'hC;         // Overrun clear

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef struct packed {
        logic        awvalid;
        logic [3:0]  awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
        logic        arvalid;
        logic [3:0]  araddr;
        logic        rready;
    } axil_m2s_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_s2m_t;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;
    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

endpackage

// ==== hw/baud_gen.sv ====
// ----------------------------------------------------------------------
// Baud tick generator
// One-cycle oversampling tick every divisor clock cycles
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module baud_gen import uart_pkg::*; (
    input  logic             i_clk,
    input  logic             i_reset,
    input  logic [DIV_W-1:0] i_divisor,         // Clocks per tick
    output logic             o_tick             // Oversampling strobe
);

    logic [DIV_W-1:0] count_q;                  // Down-counter
    logic [DIV_W-1:0] reload;                   // Next period minus one

    // Zero divisor behaves like one, tick every cycle
    assign reload = (i_divisor == '0) ? '0 : i_divisor - 1'b1;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            count_q <= '0;
            o_tick  <= 1'b0;
        end else if (count_q == '0) begin
            count_q <= reload;                  // New divisor picked up here
            o_tick  <= 1'b1;
        end else begin
            count_q <= count_q - 1'b1;
            o_tick  <= 1'b0;
        end
    end

endmodule

// ==== hw/sync_fifo.sv ====
// ----------------------------------------------------------------------
// Synchronous FIFO, 4 x 8 bits
// Head entry always visible; overflow and underflow are ignored
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module sync_fifo import uart_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_push,
    input  logic [DATA_BITS-1:0] i_push_data,
    input  logic                 i_pop,
    output logic [DATA_BITS-1:0] o_pop_data,    // Head entry
    output logic                 o_empty,
    output logic                 o_full
);

    logic [DATA_BITS-1:0] mem [2**FIFO_AW];     // Storage, no reset
    logic [FIFO_AW-1:0]   wr_ptr_q;
    logic [FIFO_AW-1:0]   rd_ptr_q;
    logic [FIFO_AW:0]     count_q;              // Occupancy 0..4
    logic                 do_push;
    logic                 do_pop;

    assign o_empty = (count_q == '0);
    assign o_full  = count_q[FIFO_AW];          // Count reached depth
    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    always_ff @(posedge i_clk) begin
        if (do_push) mem[wr_ptr_q] <= i_push_data;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;   // Natural wrap
            if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
            count_q <= count_q + do_push - do_pop;
        end
    end

    assign o_pop_data = mem[rd_ptr_q];

endmodule

// ==== hw/uart_rx.sv ====
// ----------------------------------------------------------------------
// UART receiver
// 16x oversampled, 8N1, LSB first; pulses done with a valid byte
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module uart_rx import uart_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_rx,          // Async serial input
    input  logic                 i_tick,        // Oversampling strobe
    output logic                 o_done,        // Byte ready, one cycle
    output logic [DATA_BITS-1:0] o_data         // Received byte
);

    rx_state_e             state_q;
    logic [1:0]            sync_q;              // Two-flop synchronizer
    logic                  rx_s;                // Synchronized line
    logic [TICK_W-1:0]     tick_cnt_q;
    logic [BIT_W-1:0]      bit_cnt_q;
    logic [DATA_BITS-1:0]  shift_q;
    logic                  done_q;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            sync_q <= 2'b11;                    // Idle line level
        end else begin
            sync_q <= {sync_q[0], i_rx};
        end
    end

    assign rx_s = sync_q[1];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_q    <= RX_IDLE;
            tick_cnt_q <= '0;
            bit_cnt_q  <= '0;
            done_q     <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                RX_IDLE: begin
                    tick_cnt_q <= '0;
                    if (!rx_s) state_q <= RX_START;     // Falling edge seen
                end
                RX_START: if (i_tick) begin
                    tick_cnt_q <= tick_cnt_q + 1'b1;
                    if (tick_cnt_q == TICK_HALF) begin  // Middle of start bit
                        tick_cnt_q <= '0;
                        bit_cnt_q  <= '0;
                        state_q    <= rx_s ? RX_IDLE : RX_DATA; // Glitch rejected
                    end
                end
                RX_DATA: if (i_tick) begin
                    tick_cnt_q <= tick_cnt_q + 1'b1;    // Wraps every bit
                    if (tick_cnt_q == TICK_LAST) begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q == BIT_LAST) state_q <= RX_STOP;
                    end
                end
                default: if (i_tick) begin              // RX_STOP
                    tick_cnt_q <= tick_cnt_q + 1'b1;
                    if (tick_cnt_q == TICK_LAST) begin
                        done_q  <= rx_s;                // Bad stop bit drops byte
                        state_q <= RX_IDLE;
                    end
                end
            endcase
        end
    end

    // Data bits shift in from the top, LSB arrives first
    always_ff @(posedge i_clk) begin
        if (state_q == RX_DATA && i_tick && tick_cnt_q == TICK_LAST) begin
            shift_q <= {rx_s, shift_q[DATA_BITS-1:1]};
        end
    end

    assign o_done = done_q;
    assign o_data = shift_q;

endmodule

// ==== hw/uart_tx.sv ====
// ----------------------------------------------------------------------
// UART transmitter
// Pops one byte from the TX FIFO and sends it as an 8N1 frame
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module uart_tx import uart_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_tick,        // Oversampling strobe
    input  logic                 i_fifo_empty,
    input  logic [DATA_BITS-1:0] i_fifo_data,   // FIFO head byte
    output logic                 o_fifo_pop,    // Same cycle as load
    output logic                 o_tx           // Serial line
);

    tx_state_e            state_q;
    logic [TICK_W-1:0]    tick_cnt_q;
    logic [BIT_W-1:0]     bit_cnt_q;
    logic [DATA_BITS-1:0] shift_q;
    logic                 tx_q;                 // Registered line driver
    logic                 tx_level;             // Level for current bit

    assign o_fifo_pop = (state_q == TX_IDLE) && !i_fifo_empty;

    always_comb begin
        case (state_q)
            TX_START: tx_level = 1'b0;
            TX_DATA:  tx_level = shift_q[0];
            default:  tx_level = 1'b1;          // Stop bit and idle
        endcase
    end

    // Line changes only on the first tick of each bit period
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_q    <= TX_IDLE;
            tick_cnt_q <= '0;
            bit_cnt_q  <= '0;
            tx_q       <= 1'b1;
        end else if (state_q == TX_IDLE) begin
            tick_cnt_q <= '0;
            bit_cnt_q  <= '0;
            if (!i_fifo_empty) state_q <= TX_START;
        end else if (i_tick) begin
            if (tick_cnt_q == '0) tx_q <= tx_level;
            tick_cnt_q <= tick_cnt_q + 1'b1;    // Wraps every bit
            case (state_q)
                TX_START: if (tick_cnt_q == TICK_LAST) state_q <= TX_DATA;
                TX_DATA: if (tick_cnt_q == TICK_LAST) begin
                    bit_cnt_q <= bit_cnt_q + 1'b1;
                    if (bit_cnt_q == BIT_LAST) state_q <= TX_STOP;
                end
                default: if (tick_cnt_q == STOP_LAST) state_q <= TX_IDLE;
            endcase
        end
    end

    // Byte load on pop, then shift right after each data bit
    always_ff @(posedge i_clk) begin
        if (o_fifo_pop) begin
            shift_q <= i_fifo_data;
        end else if (state_q == TX_DATA && i_tick && tick_cnt_q == TICK_LAST) begin
            shift_q <= shift_q >> 1;
        end
    end

    assign o_tx = tx_q;

endmodule

// ==== hw/uart_regs.sv ====
// ----------------------------------------------------------------------
// UART register block
// AXI4-Lite slave for DATA, STATUS, DIVISOR and CTRL; holds the divisor
// and the sticky RX overrun flag
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module uart_regs import uart_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  axil_m2s_t            i_axil,
    input  logic                 i_tx_full,
    input  logic                 i_tx_empty,
    input  logic                 i_rx_empty,
    input  logic                 i_rx_full,
    input  logic [DATA_BITS-1:0] i_rx_data,     // RX FIFO head
    input  logic                 i_rx_push,     // Receiver done pulse
    output axil_s2m_t            o_axil,
    output logic                 o_tx_push,
    output logic [DATA_BITS-1:0] o_tx_data,
    output logic                 o_rx_pop,
    output logic [DIV_W-1:0]     o_divisor
);

    logic             wr_rdy_q;                 // awready and wready
    logic             rd_rdy_q;                 // arready
    logic             bvalid_q;
    logic             rvalid_q;
    logic [1:0]       bresp_q;
    logic [1:0]       rresp_q;
    logic [31:0]      rdata_q;
    logic [DIV_W-1:0] divisor_q;
    logic             overrun_q;                // Sticky RX drop flag
    logic             wr_en;                    // Write acceptance cycle
    logic             rd_en;                    // Read acceptance cycle
    logic             wr_data_hit;
    logic             rd_data_hit;

    assign wr_en       = wr_rdy_q;              // Valids held high by manager
    assign rd_en       = rd_rdy_q;
    assign wr_data_hit = wr_en && (i_axil.awaddr == ADDR_DATA);
    assign rd_data_hit = rd_en && (i_axil.araddr == ADDR_DATA);

    assign o_tx_push = wr_data_hit && !i_tx_full;   // Full FIFO drops byte
    assign o_tx_data = i_axil.wdata[DATA_BITS-1:0];
    assign o_rx_pop  = rd_data_hit && !i_rx_empty;
    assign o_divisor = divisor_q;

    // Handshake and control state
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_rdy_q  <= 1'b0;
            rd_rdy_q  <= 1'b0;
            bvalid_q  <= 1'b0;
            rvalid_q  <= 1'b0;
            divisor_q <= DIV_RESET;
            overrun_q <= 1'b0;
        end else begin
            // One-cycle ready pulse, blocked while a response waits
            wr_rdy_q <= !wr_rdy_q && !bvalid_q && i_axil.awvalid && i_axil.wvalid;
            rd_rdy_q <= !rd_rdy_q && !rvalid_q && i_axil.arvalid;
            if (wr_en) bvalid_q <= 1'b1;
            else if (i_axil.bready) bvalid_q <= 1'b0;
            if (rd_en) rvalid_q <= 1'b1;
            else if (i_axil.rready) rvalid_q <= 1'b0;
            if (wr_en && i_axil.awaddr == ADDR_DIVISOR) begin
                if (i_axil.wstrb[0]) divisor_q[7:0]  <= i_axil.wdata[7:0];
                if (i_axil.wstrb[1]) divisor_q[15:8] <= i_axil.wdata[15:8];
            end
            if (wr_en && i_axil.awaddr == ADDR_CTRL && i_axil.wdata[0]) begin
                overrun_q <= 1'b0;              // Write 1 to clear
            end
            if (i_rx_push && i_rx_full) overrun_q <= 1'b1;  // Set wins
        end
    end

    // Response payloads, held until the handshake completes
    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            case (i_axil.awaddr)
                ADDR_DATA:    bresp_q <= i_tx_full ? RESP_SLVERR : RESP_OKAY;
                ADDR_STATUS,
                ADDR_DIVISOR,
                ADDR_CTRL:    bresp_q <= RESP_OKAY;     // STATUS write ignored
                default:      bresp_q <= RESP_SLVERR;
            endcase
        end
        if (rd_en) begin
            rdata_q <= '0;
            rresp_q <= RESP_OKAY;
            case (i_axil.araddr)
                ADDR_DATA: begin
                    if (i_rx_empty) rresp_q <= RESP_SLVERR;
                    else            rdata_q <= 32'(i_rx_data);
                end
                ADDR_STATUS:  rdata_q <= 32'({overrun_q, i_rx_full, i_rx_empty,
                                              i_tx_empty, i_tx_full});
                ADDR_DIVISOR: rdata_q <= 32'(divisor_q);
                ADDR_CTRL:    rdata_q <= '0;            // Clear bit self-clears
                default:      rresp_q <= RESP_SLVERR;
            endcase
        end
    end

    always_comb begin
        o_axil         = '0;
        o_axil.awready = wr_rdy_q;
        o_axil.wready  = wr_rdy_q;
        o_axil.bvalid  = bvalid_q;
        o_axil.bresp   = bresp_q;
        o_axil.arready = rd_rdy_q;
        o_axil.rvalid  = rvalid_q;
        o_axil.rdata   = rdata_q;
        o_axil.rresp   = rresp_q;
    end

endmodule

// ==== hw/uart_top.sv ====
// ----------------------------------------------------------------------
// UART peripheral top level
// AXI4-Lite register block steering baud generator, TX and RX paths
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module uart_top import uart_pkg::*; (
    input  logic      i_clk,
    input  logic      i_reset,
    input  axil_m2s_t i_axil,                   // Manager to UART
    input  logic      i_rx,                     // Serial in
    output axil_s2m_t o_axil,                   // UART to manager
    output logic      o_tx                      // Serial out
);

    logic                 tick;                 // Oversampling strobe
    logic [DIV_W-1:0]     divisor;
    logic                 tx_push;
    logic [DATA_BITS-1:0] tx_push_data;
    logic                 tx_pop;
    logic [DATA_BITS-1:0] tx_head;              // Next byte to send
    logic                 tx_empty;
    logic                 tx_full;
    logic                 rx_done;              // Receiver push
    logic [DATA_BITS-1:0] rx_byte;
    logic                 rx_pop;
    logic [DATA_BITS-1:0] rx_head;              // Next byte for software
    logic                 rx_empty;
    logic                 rx_full;

    uart_regs u_regs (
        .i_clk(i_clk), .i_reset(i_reset), .i_axil(i_axil),
        .i_tx_full(tx_full), .i_tx_empty(tx_empty),
        .i_rx_empty(rx_empty), .i_rx_full(rx_full),
        .i_rx_data(rx_head), .i_rx_push(rx_done), .o_axil(o_axil),
        .o_tx_push(tx_push), .o_tx_data(tx_push_data),
        .o_rx_pop(rx_pop), .o_divisor(divisor));

    baud_gen u_baud (
        .i_clk(i_clk), .i_reset(i_reset), .i_divisor(divisor), .o_tick(tick));

    sync_fifo tx_fifo (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_push(tx_push), .i_push_data(tx_push_data), .i_pop(tx_pop),
        .o_pop_data(tx_head), .o_empty(tx_empty), .o_full(tx_full));

    sync_fifo rx_fifo (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_push(rx_done), .i_push_data(rx_byte), .i_pop(rx_pop),
        .o_pop_data(rx_head), .o_empty(rx_empty), .o_full(rx_full));

    uart_tx u_tx (
        .i_clk(i_clk), .i_reset(i_reset), .i_tick(tick),
        .i_fifo_empty(tx_empty), .i_fifo_data(tx_head),
        .o_fifo_pop(tx_pop), .o_tx(o_tx));

    uart_rx u_rx (
        .i_clk(i_clk), .i_reset(i_reset), .i_rx(i_rx), .i_tick(tick),
        .o_done(rx_done), .o_data(rx_byte));

endmodule

// ==== sim/tb_uart_top.sv ====
// ----------------------------------------------------------------------
// Testbench for the UART peripheral
// AXI4-Lite register accesses, serial line monitor and loopback checks
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module tb_uart_top import uart_pkg::*; ();

    localparam int TB_DIV         = 1;                  // Divisor under test
    localparam int BIT_CYCLES     = OVERSAMPLE * TB_DIV;
    localparam int FRAME_CYCLES   = 10 * BIT_CYCLES;    // Start, 8 data, stop
    localparam int TIMEOUT_CYCLES = 20 * FRAME_CYCLES + 2000;

    logic       clk = 1'b0;
    logic       reset;
    axil_m2s_t  m2s;
    axil_s2m_t  s2m;
    logic       tx_line;
    logic       rx_line;
    logic       loop_en;                                // o_tx back into i_rx
    logic       rx_level;                               // Line level when not looped
    int         cycles = 0;
    logic [7:0] exp_tx_q [$];                           // Bytes owed on the line

    assign rx_line = loop_en ? tx_line : rx_level;

    uart_top DUT (
        .i_clk(clk), .i_reset(reset), .i_axil(m2s), .i_rx(rx_line),
        .o_axil(s2m), .o_tx(tx_line));

    always #2 clk = ~clk;                               // 4 ns period

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else
            abort_run($sformatf("error at %0t: %s got %0h, expected %0h",
                                $time, what, got, exp));
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout: the run did not finish in %0d cycles", cycles));
        end
    end

    // Serial monitor samples mid-bit and compares against accepted bytes
    always begin : serial_monitor
        logic [7:0] byte_v;
        @(negedge tx_line);
        repeat (BIT_CYCLES / 2) @(negedge clk);
        check_value("start bit", tx_line, 1'b0);
        for (int i = 0; i < DATA_BITS; i++) begin
            repeat (BIT_CYCLES) @(negedge clk);
            byte_v[i] = tx_line;                        // LSB first
        end
        repeat (BIT_CYCLES) @(negedge clk);
        check_value("stop bit", tx_line, 1'b1);
        assert (exp_tx_q.size() > 0) else
            abort_run("A frame appeared on o_tx that was never accepted");
        check_value("serial byte", byte_v, exp_tx_q.pop_front());
    end

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        @(negedge clk);
        m2s.awvalid = 1'b1;
        m2s.awaddr  = addr;
        m2s.wvalid  = 1'b1;
        m2s.wdata   = data;
        m2s.wstrb   = 4'hF;
        do @(negedge clk); while (!s2m.awready);
        check_value("wready with awready", s2m.wready, 1'b1);
        @(negedge clk);                                 // One cycle after acceptance
        check_value("bvalid", s2m.bvalid, 1'b1);
        resp        = s2m.bresp;
        m2s.awvalid = 1'b0;
        m2s.wvalid  = 1'b0;
        if (addr == ADDR_DATA && resp == RESP_OKAY) exp_tx_q.push_back(data[7:0]);
    endtask

    task automatic read_reg(input logic [3:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        @(negedge clk);
        m2s.arvalid = 1'b1;
        m2s.araddr  = addr;
        do @(negedge clk); while (!s2m.arready);
        @(negedge clk);
        check_value("rvalid", s2m.rvalid, 1'b1);
        data        = s2m.rdata;
        resp        = s2m.rresp;
        m2s.arvalid = 1'b0;
    endtask

    task automatic poll_status(input int bit_idx);
        logic [31:0] status;
        logic [1:0]  resp;
        do read_reg(ADDR_STATUS, status, resp); while (!status[bit_idx]);
    endtask

    task automatic drain_line();
        while (exp_tx_q.size() != 0) @(negedge clk);
        repeat (BIT_CYCLES) @(negedge clk);             // Rest of the stop bit
    endtask

    initial begin : main
        logic [31:0] rdata;
        logic [1:0]  resp;
        logic [7:0]  sent [5];
        reset    = 1'b1;
        m2s      = '0;
        m2s.bready = 1'b1;                              // Never back-pressure
        m2s.rready = 1'b1;
        loop_en  = 1'b0;
        rx_level = 1'b1;
        void'($urandom(32'hcacc852a));
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Reset state
        check_value("o_tx after reset", tx_line, 1'b1);
        read_reg(ADDR_STATUS, rdata, resp);
        check_value("STATUS resp", resp, RESP_OKAY);
        check_value("STATUS flags", rdata[4:0], 5'b00110);  // rx_empty, tx_empty
        read_reg(ADDR_DIVISOR, rdata, resp);
        check_value("DIVISOR after reset", rdata, DIV_RESET);

        // Serial format of one byte
        write_reg(ADDR_DIVISOR, TB_DIV, resp);
        check_value("DIVISOR write resp", resp, RESP_OKAY);
        sent[0] = 8'($urandom);
        write_reg(ADDR_DATA, sent[0], resp);
        check_value("DATA write resp", resp, RESP_OKAY);
        drain_line();

        // Loopback of four bytes
        loop_en = 1'b1;
        for (int i = 0; i < 4; i++) begin
            sent[i] = 8'($urandom);
            write_reg(ADDR_DATA, sent[i], resp);
            check_value("DATA write resp", resp, RESP_OKAY);
        end
        poll_status(3);                                 // rx_full
        for (int i = 0; i < 4; i++) begin
            read_reg(ADDR_DATA, rdata, resp);
            check_value("RX DATA resp", resp, RESP_OKAY);
            check_value("RX byte", rdata, sent[i]);
        end
        drain_line();

        // TX FIFO full and error responses
        loop_en = 1'b0;
        for (int i = 0; i < 6; i++) begin
            write_reg(ADDR_DATA, 8'($urandom), resp);
            if (i == 5) check_value("sixth DATA write resp", resp, RESP_SLVERR);
        end
        read_reg(ADDR_STATUS, rdata, resp);
        check_value("STATUS tx_full", rdata[0], 1'b1);
        drain_line();
        read_reg(ADDR_DATA, rdata, resp);
        check_value("empty RX DATA resp", resp, RESP_SLVERR);
        check_value("empty RX DATA value", rdata, 32'h0);
        read_reg(4'h2, rdata, resp);
        check_value("unmapped read resp", resp, RESP_SLVERR);
        write_reg(4'hA, 32'h7, resp);
        check_value("unmapped write resp", resp, RESP_SLVERR);
        read_reg(ADDR_DIVISOR, rdata, resp);
        check_value("DIVISOR after unmapped write", rdata, TB_DIV);

        // Overrun on the fifth received byte
        loop_en = 1'b1;
        for (int i = 0; i < 5; i++) begin
            sent[i] = 8'($urandom);
            write_reg(ADDR_DATA, sent[i], resp);
            check_value("DATA write resp", resp, RESP_OKAY);
            drain_line();
        end
        poll_status(4);                                 // Overrun
        read_reg(ADDR_STATUS, rdata, resp);
        check_value("STATUS rx_full on overrun", rdata[3], 1'b1);
        for (int i = 0; i < 4; i++) begin
            read_reg(ADDR_DATA, rdata, resp);
            check_value("RX DATA resp", resp, RESP_OKAY);
            check_value("RX byte after overrun", rdata, sent[i]);
        end
        write_reg(ADDR_CTRL, 32'h1, resp);
        check_value("CTRL write resp", resp, RESP_OKAY);
        read_reg(ADDR_STATUS, rdata, resp);
        check_value("overrun after clear", rdata[4], 1'b0);
        check_value("rx_empty after clear", rdata[2], 1'b1);

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== src.f ====
hw/uart_pkg.sv
hw/baud_gen.sv
hw/sync_fifo.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/uart_regs.sv
hw/uart_top.sv
sim/tb_uart_top.sv
